// ==== hw/bit_clock_timer.sv ====
`timescale 1ns/10ps

module bit_clock_timer #(
    parameter int half_period = 4,                // ack cycles per psx_clk half
    parameter int ack_timeout = 64                // ack cycles allowed for pad_ack
) (
    input  logic ack,
    input  logic reset,
    input  logic bit_run,                         // sequencer wants half ticks
    input  logic ack_arm,                         // acknowledge window open
    output logic half_tick,                       // one cycle per half bit
    output logic ack_expired                      // window ran out
);

    // counters need at least one bit even for tiny settings
    localparam int hw = (half_period > 1) ? $clog2(half_period) : 1;
    localparam int aw = (ack_timeout > 1) ? $clog2(ack_timeout) : 1;

    logic [hw-1:0] half_cnt;                      // cycles left in this half
    logic [aw-1:0] ack_cnt;                       // cycles left in the window

    // half bit counter
    // held at full count while idle so the first tick lands one
    // whole half period after bit_run goes high
    always_ff @(posedge ack) begin
        if (reset || !bit_run) begin
            half_cnt <= hw'(half_period - 1);     // park at top of count
        end else if (half_cnt == '0) begin
            half_cnt <= hw'(half_period - 1);     // reload, tick seen this cycle
        end else begin
            half_cnt <= half_cnt - 1'b1;
        end
    end

    assign half_tick = bit_run && (half_cnt == '0);   // last cycle of each half

    // acknowledge window
    // loaded while disarmed, so arming starts a fresh window of
    // ack_timeout cycles with the last one flagged as expired
    always_ff @(posedge ack) begin
        if (reset || !ack_arm) begin
            ack_cnt <= aw'(ack_timeout - 1);      // ready for next arm
        end else if (ack_cnt != '0) begin
            ack_cnt <= ack_cnt - 1'b1;            // window running
        end
    end

    assign ack_expired = ack_arm && (ack_cnt == '0);  // stays up until disarmed

endmodule

// ==== hw/byte_shifter.sv ====
`timescale 1ns/10ps

module byte_shifter (
    input  logic ack,
    input  logic reset,
    input  logic half_tick,                       // from bit_clock_timer
    input  logic pad_data,                        // serial data from the pad
    output logic psx_clk,                         // idles high
    output logic cmd,                             // idles high
    pad_byte_if.shift_mp link
);
    import psx_pkg::*;

    localparam int halves = 2 * byte_w;           // one low and one high half per bit
    localparam int cnt_w  = $clog2(halves);

    logic [cnt_w-1:0] half_cnt;                   // ticks seen in this byte
    byte_t            tx_sr;                      // remaining command bits
    byte_t            rx_sr;                      // data bits, fills from the top
    logic             busy_q;
    logic             done_q;

    // control path
    always_ff @(posedge ack) begin
        if (reset) begin
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            psx_clk  <= 1'b1;
            cmd      <= 1'b1;
            half_cnt <= '0;
        end else begin
            done_q <= 1'b0;                       // pulse only
            if (link.start && !busy_q) begin
                busy_q   <= 1'b1;
                half_cnt <= '0;
                psx_clk  <= 1'b0;                 // first falling edge right away
                cmd      <= link.tx_byte[0];      // lsb first
            end else if (busy_q && half_tick) begin
                if (half_cnt == cnt_w'(halves - 1)) begin
                    busy_q <= 1'b0;               // sixteenth half over
                    done_q <= 1'b1;
                    cmd    <= 1'b1;               // release cmd between bytes
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                    psx_clk  <= ~half_cnt[0];     // even count rises, odd count falls
                    if (half_cnt[0]) begin
                        cmd <= tx_sr[0];          // next bit on the falling edge
                    end
                end
            end
        end
    end

    // payload shift registers
    always_ff @(posedge ack) begin
        if (link.start && !busy_q) begin
            tx_sr <= {1'b1, link.tx_byte[byte_w-1:1]};    // bit 0 already on cmd
        end else if (busy_q && half_tick && half_cnt != cnt_w'(halves - 1)) begin
            if (half_cnt[0]) begin
                tx_sr <= {1'b1, tx_sr[byte_w-1:1]};       // falling half
            end else begin
                rx_sr <= {pad_data, rx_sr[byte_w-1:1]};   // rising half, sample pad
            end
        end
    end

    assign link.busy    = busy_q;
    assign link.done    = done_q;
    assign link.rx_byte = rx_sr;                  // untouched until the next start

endmodule

// ==== hw/pad_byte_if.sv ====
`timescale 1ns/10ps

interface pad_byte_if;
    import psx_pkg::*;

    logic  start;                                 // one cycle, only while busy low
    byte_t tx_byte;                               // captured on start
    logic  busy;                                  // shifter owns the pad lines
    logic  done;                                  // one cycle, byte finished
    byte_t rx_byte;                               // valid from done until next start

    // poll side picks the byte and waits for completion
    modport seq_mp (
        output start,
        output tx_byte,
        input  busy,
        input  done,
        input  rx_byte
    );

    // shifter side runs the serial transfer
    modport shift_mp (
        input  start,
        input  tx_byte,
        output busy,
        output done,
        output rx_byte
    );

endinterface

// ==== hw/poll_sequencer.sv ====
`timescale 1ns/10ps

module poll_sequencer #(
    parameter int max_credits = 2,                // credits held after reset
    parameter int credit_w    = 2                 // fits 0 .. max_credits
) (
    input  logic               ack,
    input  logic               reset,
    input  logic               poll,              // consumer asks for a frame
    input  logic               credit_return,     // consumer freed one frame
    input  logic               pad_ack,           // active low from the pad
    input  logic               half_tick,
    input  logic               ack_expired,
    output logic               att,               // pad select, active low
    output logic               bit_run,
    output logic               ack_arm,
    output logic               frame_valid,
    output psx_pkg::byte_t     frame_id,
    output psx_pkg::buttons_t  frame_buttons,
    output logic               pad_missing,
    pad_byte_if.seq_mp         link
);
    import psx_pkg::*;

    localparam byte_idx_t last_idx = byte_idx_t'(poll_len - 1);

    seq_state_t          state;
    byte_idx_t           idx;                     // byte being sent or next to send
    logic                half_seen;               // first setup tick passed
    logic                start_q;
    logic [credit_w-1:0] credits;
    logic [credit_w:0]   credit_sum;              // one extra bit for the add
    logic                take;                    // poll accepted this cycle
    logic                refund;                  // failed poll gives its credit back

    assign take   = (state == idle) && poll && (credits != '0);
    assign refund = (state == abort);

    // credit arithmetic, capped at max_credits
    always_comb begin
        credit_sum = {1'b0, credits}
                   + (credit_w + 1)'(credit_return)
                   + (credit_w + 1)'(refund)
                   - (credit_w + 1)'(take);       // take needs credits above zero
    end

    // poll FSM
    always_ff @(posedge ack) begin
        if (reset) begin
            state     <= idle;
            att       <= 1'b1;
            start_q   <= 1'b0;
            idx       <= '0;
            half_seen <= 1'b0;
            credits   <= credit_w'(max_credits);
        end else begin
            start_q <= 1'b0;                      // pulse only
            if (credit_sum > (credit_w + 1)'(max_credits)) begin
                credits <= credit_w'(max_credits);
            end else begin
                credits <= credit_sum[credit_w-1:0];
            end

            case (state)
                idle: begin
                    if (take) begin
                        state     <= att_setup;
                        att       <= 1'b0;        // select the pad
                        idx       <= '0;
                        half_seen <= 1'b0;
                    end
                end
                att_setup: begin
                    if (half_tick) begin
                        half_seen <= 1'b1;
                        if (half_seen) begin      // two halves of settling done
                            start_q <= 1'b1;
                            state   <= xfer;
                        end
                    end
                end
                xfer: begin
                    if (link.done) begin
                        if (idx == last_idx) begin
                            state <= finish;
                            att   <= 1'b1;        // rises with frame_valid
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= ack_wait;
                        end
                    end
                end
                ack_wait: begin
                    // pad_ack wins over a window that ends in the same cycle
                    if (!pad_ack && !link.busy) begin
                        start_q <= 1'b1;
                        state   <= xfer;
                    end else if (ack_expired) begin
                        state <= abort;
                        att   <= 1'b1;            // rises with pad_missing
                    end
                end
                finish: state <= idle;
                abort:  state <= idle;            // credit comes back here
                default: begin
                    state <= idle;
                    att   <= 1'b1;
                end
            endcase
        end
    end

    // frame assembly, fields land as their bytes complete
    always_ff @(posedge ack) begin
        if (state == xfer && link.done) begin
            case (idx)
                id_pos:     frame_id                          <= link.rx_byte;
                btn_lo_pos: frame_buttons[byte_w-1:0]         <= link.rx_byte;
                btn_hi_pos: frame_buttons[buttons_w-1:byte_w] <= link.rx_byte;
                default:    ;                     // 0xff and 0x5a not kept
            endcase
        end
    end

    assign link.start   = start_q;
    assign link.tx_byte = poll_bytes[idx];        // held steady through the byte

    // timer restarts with the first falling edge of each byte
    assign bit_run     = (state == att_setup) || (state == xfer && link.busy);
    assign ack_arm     = (state == ack_wait);
    assign frame_valid = (state == finish);       // one cycle, same as att rise
    assign pad_missing = (state == abort);

endmodule

// ==== hw/psx_pad_host.sv ====
`timescale 1ns/10ps

module psx_pad_host #(
    parameter int half_period = 4,                // ack cycles per psx_clk half
    parameter int ack_timeout = 64,               // ack cycles allowed for pad_ack
    parameter int max_credits = 2                 // frames the consumer can buffer
) (
    input  logic              ack,                // system clock
    input  logic              reset,
    // pad side
    input  logic              pad_data,
    input  logic              pad_ack,
    output logic              psx_clk,
    output logic              cmd,
    output logic              att,
    // consumer side
    input  logic              poll,
    output logic              frame_valid,
    output psx_pkg::byte_t    frame_id,
    output psx_pkg::buttons_t frame_buttons,
    input  logic              credit_return,
    output logic              pad_missing
);

    localparam int credit_w = $clog2(max_credits + 1);  // counts 0 .. max_credits

    logic bit_run;
    logic ack_arm;
    logic half_tick;
    logic ack_expired;

    pad_byte_if link ();                          // sequencer to shifter

    bit_clock_timer #(
        .half_period (half_period),
        .ack_timeout (ack_timeout)
    ) u_timer (
        .ack         (ack),
        .reset       (reset),
        .bit_run     (bit_run),
        .ack_arm     (ack_arm),
        .half_tick   (half_tick),
        .ack_expired (ack_expired)
    );

    byte_shifter u_shifter (
        .ack       (ack),
        .reset     (reset),
        .half_tick (half_tick),
        .pad_data  (pad_data),
        .psx_clk   (psx_clk),
        .cmd       (cmd),
        .link      (link.shift_mp)
    );

    poll_sequencer #(
        .max_credits (max_credits),
        .credit_w    (credit_w)
    ) u_seq (
        .ack           (ack),
        .reset         (reset),
        .poll          (poll),
        .credit_return (credit_return),
        .pad_ack       (pad_ack),
        .half_tick     (half_tick),
        .ack_expired   (ack_expired),
        .att           (att),
        .bit_run       (bit_run),
        .ack_arm       (ack_arm),
        .frame_valid   (frame_valid),
        .frame_id      (frame_id),
        .frame_buttons (frame_buttons),
        .pad_missing   (pad_missing),
        .link          (link.seq_mp)
    );

endmodule

// ==== hw/psx_pkg.sv ====
package psx_pkg;

    // link framing
    localparam int byte_w    = 8;                // bits per byte on cmd and data
    localparam int buttons_w = 2 * byte_w;       // two button bytes per digital frame

    typedef logic [byte_w-1:0]    byte_t;         // one byte on the link
    typedef logic [buttons_w-1:0] buttons_t;      // low while pressed, byte 3 in low half

    // digital poll
    localparam int poll_len = 5;                  // header, id, ready, two button bytes

    typedef logic [2:0] byte_idx_t;               // position within the poll

    // command bytes in send order, each goes out lsb first
    localparam byte_t poll_bytes [poll_len] = '{
        8'h01,                                    // start of packet
        8'h42,                                    // read data
        8'h00,                                    // idle while pad sends 0x5a
        8'h00,                                    // idle while pad sends buttons low
        8'h00                                     // idle while pad sends buttons high
    };

    // which received byte feeds which frame field
    localparam byte_idx_t id_pos     = 3'd1;      // pad id, 0x41 for a digital pad
    localparam byte_idx_t btn_lo_pos = 3'd3;      // select, start, d-pad
    localparam byte_idx_t btn_hi_pos = 3'd4;      // shoulders and face buttons

    // sequencer states
    typedef enum logic [2:0] {
        idle,                                     // no poll running
        att_setup,                                // att low, settling before byte 0
        xfer,                                     // shifter busy with one byte
        ack_wait,                                 // window open for pad acknowledge
        finish,                                   // frame handed to the consumer
        abort                                     // pad silent, poll dropped
    } seq_state_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pad host testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_psx_pad_host \
    --Mdir obj_dir -o sim_psx_pad_host \
    -f src.f

out=$(./obj_dir/sim_psx_pad_host)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi

// ==== src.f ====
hw/psx_pkg.sv
hw/pad_byte_if.sv
hw/bit_clock_timer.sv
hw/byte_shifter.sv
hw/poll_sequencer.sv
hw/psx_pad_host.sv
tb/psx_pad_host_properties.sv
tb/tb_psx_pad_host.sv

// ==== tb/psx_pad_host_properties.sv ====
`timescale 1ns/10ps

module psx_pad_host_properties (
    input logic ack,
    input logic reset,
    input logic att,
    input logic psx_clk,
    input logic cmd,
    input logic frame_valid,
    input logic pad_missing
);

    // lines parked high straight out of reset
    a_idle_after_reset: assert property (@(posedge ack)
        reset |=> att && psx_clk && cmd && !frame_valid && !pad_missing)
        else $error("pad lines not idle after reset");

    // psx_clk only moves while the pad is selected
    a_clk_needs_att: assert property (@(posedge ack) disable iff (reset)
        $changed(psx_clk) |-> !att)
        else $error("psx_clk toggled with att high");

    // deselected pad sees idle cmd and clock
    a_lines_idle: assert property (@(posedge ack) disable iff (reset)
        att |-> cmd && psx_clk)
        else $error("cmd or psx_clk low with att high");

    // cmd may only be released to high during a high clock phase
    a_cmd_steady: assert property (@(posedge ack) disable iff (reset)
        (psx_clk && $past(psx_clk) && $changed(cmd)) |-> cmd)
        else $error("cmd changed while psx_clk high");

    // every poll ends with att rising together with its result
    a_end_with_att: assert property (@(posedge ack) disable iff (reset)
        (frame_valid || pad_missing) |-> $rose(att))
        else $error("poll result without att rise");

    a_valid_pulse: assert property (@(posedge ack) disable iff (reset)
        frame_valid |=> !frame_valid)
        else $error("frame_valid longer than one cycle");

    a_missing_pulse: assert property (@(posedge ack) disable iff (reset)
        pad_missing |=> !pad_missing)
        else $error("pad_missing longer than one cycle");

    // at least one idle cycle between polls
    a_att_gap: assert property (@(posedge ack) disable iff (reset)
        $rose(att) |=> att)
        else $error("att fell right after rising");

endmodule

bind psx_pad_host psx_pad_host_properties u_props (
    .ack         (ack),
    .reset       (reset),
    .att         (att),
    .psx_clk     (psx_clk),
    .cmd         (cmd),
    .frame_valid (frame_valid),
    .pad_missing (pad_missing)
);

// ==== tb/tb_psx_pad_host.sv ====
`timescale 1ns/10ps

module tb_psx_pad_host;

    localparam int half_period = 4;
    localparam int ack_timeout = 64;
    localparam int max_credits = 2;
    localparam int num_polls   = 9;                              // 4 good, 2 in timeout test, 3 credit
    localparam int cycle_limit = 6 * (num_polls * (80 * half_period + 4 * 20) + 100);
    localparam int poll_window = 80 * half_period + 4 * (half_period + 23) + 50;

    logic ack, reset, pad_data, pad_ack, poll, credit_return;
    logic psx_clk, cmd, att, frame_valid, pad_missing;
    logic [7:0]  frame_id;
    logic [15:0] frame_buttons;

    integer seed = 32'h6ccd096f;
    int cycle = 0, errors = 0, frames_seen = 0, missing_seen = 0;
    int pending = 0;                                             // credits owed by the consumer
    int edge_cnt = 0, last_edge = 0, byte0_end = 0;
    bit hold = 0, withhold = 0;
    logic [7:0]  cmd_sr;
    logic [15:0] exp_q [$];                                      // button words the pad sent

    psx_pad_host #(
        .half_period (half_period),
        .ack_timeout (ack_timeout),
        .max_credits (max_credits)
    ) uut (
        .ack (ack), .reset (reset), .pad_data (pad_data), .pad_ack (pad_ack),
        .psx_clk (psx_clk), .cmd (cmd), .att (att), .poll (poll),
        .frame_valid (frame_valid), .frame_id (frame_id), .frame_buttons (frame_buttons),
        .credit_return (credit_return), .pad_missing (pad_missing)
    );

    initial begin
        ack = 1'b0;
        forever #2 ack = ~ack;                                   // 4 ns period
    end

    always @(posedge ack) begin
        cycle = cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("run stopped: cycle limit of %0d reached", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic note_failure(input string what);
        errors++;
        $display("%0t: %s", $time, what);
    endtask

    // command byte n of a digital poll
    function automatic logic [7:0] poll_cmd(input int n);
        case (n)
            0:       return 8'h01;
            1:       return 8'h42;
            default: return 8'h00;
        endcase
    endfunction

    // pad model, answers one poll
    task automatic serve_poll();
        logic [39:0] resp;
        logic [7:0]  lo, hi;
        int          n_bytes, gap;
        lo = 8'($random(seed));
        hi = 8'($random(seed));
        resp = {hi, lo, 8'h5a, 8'h41, 8'hff};                    // byte 0 in the low bits
        if (withhold) begin
            n_bytes = 1;                                         // stays silent after byte 0
        end else begin
            n_bytes = 5;
            exp_q.push_back({hi, lo});
        end
        for (int b = 0; b < n_bytes; b++) begin
            for (int i = 0; i < 8; i++) begin
                @(negedge psx_clk);
                #1 pad_data = resp[0];                           // lsb first
                resp = resp >> 1;
                @(posedge psx_clk);
            end
            if (b < 4 && !withhold) begin
                gap = 3 + int'({$random(seed)} % 18);            // 3 .. 20 cycles after done
                fork
                    begin
                        repeat (half_period + 1 + gap) @(posedge ack);
                        #1 pad_ack = 1'b0;
                        repeat (2) @(posedge ack);
                        #1 pad_ack = 1'b1;
                    end
                join_none
            end
        end
        #1 pad_data = 1'b1;
    endtask

    initial begin
        forever begin
            @(negedge att);
            serve_poll();
        end
    end

    // consumer hands credits back after a short random delay
    initial begin
        forever begin
            @(posedge ack);
            #1;
            if (pending > 0) begin
                repeat (1 + {$random(seed)} % 10) @(posedge ack);
                #1 credit_return = 1'b1;
                @(posedge ack);
                #1 credit_return = 1'b0;
                pending--;
            end
        end
    end

    always @(negedge att) edge_cnt = 0;

    // bus framing, spacing of psx_clk edges and cmd bits
    always @(psx_clk) begin
        if (att === 1'b0) begin
            edge_cnt++;
            if (edge_cnt % 16 != 1)
                assert (cycle - last_edge == half_period)
                    else note_failure("psx_clk half period has the wrong length");
            last_edge = cycle;
            if (psx_clk) begin
                cmd_sr = {cmd, cmd_sr[7:1]};                     // sample at rising edge
                if (edge_cnt % 16 == 0) begin
                    assert (cmd_sr == poll_cmd(edge_cnt / 16 - 1)) else begin
                        errors++;
                        $display("ERROR cmd got %h expected %h", cmd_sr,
                                 poll_cmd(edge_cnt / 16 - 1));
                    end
                    if (edge_cnt == 16) byte0_end = cycle;
                end
            end
        end
    end

    always @(posedge att) begin
        #1;
        if (frame_valid) begin
            assert (edge_cnt == 80) else note_failure("good poll did not run five bytes");
        end else if (pad_missing) begin
            assert (edge_cnt == 16) else note_failure("aborted poll did not stop after byte 0");
        end else if (!reset) begin
            note_failure("att rose without frame_valid or pad_missing");
        end
    end

    always @(posedge pad_missing) begin
        missing_seen++;
        assert (cycle == byte0_end + half_period + ack_timeout + 1) else begin
            errors++;
            $display("ERROR pad_missing cycle got %h expected %h", cycle,
                     byte0_end + half_period + ack_timeout + 1);
        end
    end

    // frame contents against what the pad model sent
    always @(posedge ack) begin
        logic [15:0] exp;
        if (!reset && frame_valid) begin
            frames_seen++;
            if (!hold) pending++;
            if (exp_q.size() == 0) begin
                note_failure("frame delivered that the pad never sent");
            end else begin
                exp = exp_q.pop_front();
                assert (frame_id == 8'h41) else begin
                    errors++;
                    $display("ERROR frame_id got %h expected %h", frame_id, 8'h41);
                end
                assert (frame_buttons == exp) else begin
                    errors++;
                    $display("ERROR frame_buttons got %h expected %h", frame_buttons, exp);
                end
            end
        end
    end

    // one poll, waits for its result with a bounded window
    task automatic run_poll(input bit expect_missing);
        bit seen_frame, seen_missing;
        int n;
        seen_frame = 0;
        seen_missing = 0;
        n = 0;
        poll = 1'b1;
        while (att) begin
            @(posedge ack);
            #1;
        end
        poll = 1'b0;
        while (!seen_frame && !seen_missing && n < poll_window) begin
            @(posedge ack);
            #1;
            seen_frame = frame_valid;
            seen_missing = pad_missing;
            n++;
        end
        if (expect_missing)
            assert (seen_missing && !seen_frame) else note_failure("expected pad_missing never came");
        else
            assert (seen_frame && !seen_missing) else note_failure("expected frame_valid never came");
        repeat (2) @(posedge ack);
        #1;
    endtask

    initial begin
        int base;
        reset = 1'b1;
        pad_data = 1'b1;
        pad_ack = 1'b1;
        poll = 1'b0;
        credit_return = 1'b0;
        repeat (8) @(posedge ack);
        #1 reset = 1'b0;
        repeat (5) begin
            @(posedge ack);
            #1;
            assert (att && psx_clk && cmd && !frame_valid && !pad_missing)
                else note_failure("outputs not idle after reset");
        end
        repeat (4) run_poll(1'b0);
        withhold = 1'b1;                                         // pad goes silent
        run_poll(1'b1);
        withhold = 1'b0;
        assert (missing_seen == 1) else note_failure("pad_missing did not pulse exactly once");
        run_poll(1'b0);
        repeat (40) @(posedge ack);                              // let credits come home
        #1 hold = 1'b1;
        base = frames_seen;
        poll = 1'b1;
        while (frames_seen - base < max_credits && cycle < cycle_limit) begin
            @(posedge ack);
            #1;
        end
        repeat (poll_window) begin
            @(posedge ack);
            #1;
            assert (att) else note_failure("att fell with no credit left");
        end
        assert (frames_seen - base == max_credits) else note_failure("too many frames without credit");
        pending++;                                               // one credit back
        repeat (2 * poll_window) @(posedge ack);
        #1 poll = 1'b0;
        assert (frames_seen - base == max_credits + 1)
            else note_failure("one credit_return did not give exactly one poll");
        hold = 1'b0;
        $display("summary: %0d errors, %0d frames, %0d pad_missing", errors, frames_seen,
                 missing_seen);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
